// File: design/aud_ctrl_pkg.sv
package aud_ctrl_pkg;

	// state register width
	localparam int STATE_W = 3;

	// speed factor field, 0 means normal speed
	localparam int FACTOR_W = 3;

	// controller states
	typedef enum logic [STATE_W-1:0] {
		S_STOP,
		S_RECD,
		S_RECD_PAUSE,
		S_PLAY,
		S_PLAY_PAUSE
	} ctrl_state_e;

	// raw key levels, acted on at release
	typedef struct packed {
		logic rec;
		logic play;
		logic stop;
	} key_s;

	// only the active states count, pauses read as idle
	typedef struct packed {
		logic recording;
		logic playing;
	} status_s;

	// slow=0 skips factor samples per frame
	// slow=1 holds each sample for factor+1 frames
	typedef struct packed {
		logic                slow;
		logic [FACTOR_W-1:0] factor;
	} speed_s;

	// enables are levels, restarts are one-cycle pulses
	typedef struct packed {
		logic rec_en;
		logic play_en;
		logic rec_restart;
		logic play_restart;
	} ctrl_cmd_s;

endpackage

// File: design/aud_data_pkg.sv
package aud_data_pkg;

	// codec word, left channel only
	localparam int SAMPLE_W = 16;

	// external SRAM depth is 1M words
	localparam int ADDR_W = 20;

	// counts the bits of one word on the I2S line
	localparam int BIT_CNT_W = $clog2(SAMPLE_W);

	// one SRAM access per cycle
	// we_n low writes wdata at addr, otherwise addr selects the read word
	typedef struct packed {
		logic                we_n;
		logic [ADDR_W-1:0]   addr;
		logic [SAMPLE_W-1:0] wdata;
	} sram_req_s;

endpackage

// File: design/aud_ctrl_fsm.sv
`timescale 1ns/1ps

module aud_ctrl_fsm (
	input  logic                    i_AUD_BCLK,
	input  logic                    i_rst_n,
	input  aud_ctrl_pkg::key_s      i_keys,
	input  logic                    i_play_done,
	output aud_ctrl_pkg::ctrl_cmd_s o_cmd,
	output aud_ctrl_pkg::status_s   o_status
);

	import aud_ctrl_pkg::*;

	ctrl_state_e state_r, state_w;
	key_s        keys_r;
	key_s        rel;
	status_s     status_r, status_w;
	logic        rec_restart;
	logic        play_restart;

	// released means high last cycle and low now
	assign rel.rec  = keys_r.rec & ~i_keys.rec;
	assign rel.play = keys_r.play & ~i_keys.play;
	assign rel.stop = keys_r.stop & ~i_keys.stop;

	always_comb begin
		state_w      = state_r;
		rec_restart  = 1'b0;
		play_restart = 1'b0;
		case (state_r)
			S_STOP: begin
				if (rel.rec) begin
					state_w     = S_RECD;
					rec_restart = 1'b1;
				end else if (rel.play) begin
					state_w      = S_PLAY;
					play_restart = 1'b1;
				end
			end
			S_RECD: begin
				if (rel.stop) begin
					state_w = S_STOP;
				end else if (rel.rec) begin
					state_w = S_RECD_PAUSE;
				end
			end
			S_RECD_PAUSE: begin
				if (rel.stop) begin
					state_w = S_STOP;
				end else if (rel.rec) begin
					state_w = S_RECD;
				end
			end
			S_PLAY: begin
				// end of recording behaves like stop
				if (rel.stop || i_play_done) begin
					state_w = S_STOP;
				end else if (rel.play) begin
					state_w = S_PLAY_PAUSE;
				end
			end
			S_PLAY_PAUSE: begin
				if (rel.stop) begin
					state_w = S_STOP;
				end else if (rel.play) begin
					state_w = S_PLAY;
				end
			end
			default: begin
				state_w = S_STOP;
			end
		endcase
	end

	// decoded from the next state so status lines up with state_r
	always_comb begin
		status_w.recording = (state_w == S_RECD);
		status_w.playing   = (state_w == S_PLAY);
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			state_r  <= S_STOP;
			keys_r   <= '0;
			status_r <= '0;
		end else begin
			state_r  <= state_w;
			keys_r   <= i_keys;
			status_r <= status_w;
		end
	end

	// restarts fire with the transition so the counter is cleared on entry
	always_comb begin
		o_cmd.rec_en       = (state_r == S_RECD);
		o_cmd.play_en      = (state_r == S_PLAY);
		o_cmd.rec_restart  = rec_restart;
		o_cmd.play_restart = play_restart;
	end

	assign o_status = status_r;

endmodule

// File: design/aud_addr_counter.sv
`timescale 1ns/1ps

module aud_addr_counter (
	input  logic                            i_AUD_BCLK,
	input  logic                            i_rst_n,
	input  aud_ctrl_pkg::ctrl_cmd_s         i_cmd,
	input  aud_ctrl_pkg::speed_s            i_speed,
	input  logic                            i_sample_valid,
	input  logic                            i_frame_start,
	output logic [aud_data_pkg::ADDR_W-1:0] o_rec_addr,
	output logic [aud_data_pkg::ADDR_W-1:0] o_play_addr,
	output logic                            o_play_done
);

	import aud_ctrl_pkg::*;
	import aud_data_pkg::*;

	logic [ADDR_W-1:0]   rec_addr_r;
	logic [ADDR_W-1:0]   rec_len_r;
	logic [ADDR_W-1:0]   play_addr_r;
	logic [FACTOR_W-1:0] rep_cnt_r;
	logic                rec_en_r;
	logic                play_done_r;
	logic                step;
	logic [ADDR_W:0]     incr;
	logic [ADDR_W:0]     next_addr;

	// slow mode moves only once the word has been held factor+1 frames
	assign step = ~i_speed.slow | (rep_cnt_r >= i_speed.factor);

	// one extra bit so the end check survives a large fast step
	assign incr = i_speed.slow ? {{ADDR_W{1'b0}}, step}
		: {{(ADDR_W + 1 - FACTOR_W){1'b0}}, i_speed.factor} + 1'b1;
	assign next_addr = {1'b0, play_addr_r} + incr;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			rec_addr_r  <= '0;
			rec_len_r   <= '0;
			play_addr_r <= '0;
			rep_cnt_r   <= '0;
			rec_en_r    <= 1'b0;
			play_done_r <= 1'b0;
		end else begin
			rec_en_r    <= i_cmd.rec_en;
			play_done_r <= 1'b0;
			if (i_cmd.rec_restart) begin
				rec_addr_r <= '0;
			end else if (i_cmd.rec_en && i_sample_valid) begin
				rec_addr_r <= rec_addr_r + 1'b1;
			end
			// no writes while paused, so the last fall of rec_en gives the length
			if (rec_en_r && !i_cmd.rec_en) begin
				rec_len_r <= rec_addr_r;
			end
			if (i_cmd.play_restart) begin
				play_addr_r <= '0;
				rep_cnt_r   <= '0;
			end else if (i_cmd.play_en && i_frame_start) begin
				if (next_addr >= {1'b0, rec_len_r}) begin
					play_done_r <= 1'b1;
				end else begin
					play_addr_r <= next_addr[ADDR_W-1:0];
					rep_cnt_r   <= step ? '0 : rep_cnt_r + 1'b1;
				end
			end
		end
	end

	assign o_rec_addr  = rec_addr_r;
	assign o_play_addr = play_addr_r;
	assign o_play_done = play_done_r;

endmodule

// File: design/i2s_recorder.sv
`timescale 1ns/1ps

module i2s_recorder (
	input  logic                              i_AUD_BCLK,
	input  logic                              i_rst_n,
	input  logic                              i_AUD_ADCLRCK,
	input  logic                              i_AUD_ADCDAT,
	output logic [aud_data_pkg::SAMPLE_W-1:0] o_sample,
	output logic                              o_sample_valid
);

	import aud_data_pkg::*;

	logic                 lrck_r;
	logic                 fall;
	logic                 capture_r;
	logic [BIT_CNT_W-1:0] bit_cnt_r;
	logic [SAMPLE_W-1:0]  shift_r;
	logic                 valid_r;

	// left half starts at the LRCK falling edge
	assign fall = lrck_r & ~i_AUD_ADCLRCK;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_r    <= 1'b0;
			capture_r <= 1'b0;
			bit_cnt_r <= '0;
			valid_r   <= 1'b0;
		end else begin
			lrck_r  <= i_AUD_ADCLRCK;
			valid_r <= 1'b0;
			if (fall) begin
				// MSB comes on the next edge
				capture_r <= 1'b1;
				bit_cnt_r <= '0;
			end else if (capture_r) begin
				bit_cnt_r <= bit_cnt_r + 1'b1;
				if (bit_cnt_r == BIT_CNT_W'(SAMPLE_W - 1)) begin
					capture_r <= 1'b0;
					valid_r   <= 1'b1;
				end
			end
		end
	end

	// right channel bits fall outside the capture window
	always_ff @(posedge i_AUD_BCLK) begin
		if (capture_r) begin
			shift_r <= {shift_r[SAMPLE_W-2:0], i_AUD_ADCDAT};
		end
	end

	// word stays put until the next left half begins
	assign o_sample       = shift_r;
	assign o_sample_valid = valid_r;

endmodule

// File: design/i2s_player.sv
`timescale 1ns/1ps

module i2s_player (
	input  logic                              i_AUD_BCLK,
	input  logic                              i_rst_n,
	input  logic                              i_AUD_DACLRCK,
	input  logic                              i_en,
	input  logic [aud_data_pkg::SAMPLE_W-1:0] i_sram_rdata,
	output logic                              o_frame_start,
	output logic                              o_AUD_DACDAT
);

	import aud_data_pkg::*;

	logic                 lrck_r;
	logic                 fall;
	logic                 active_r;
	logic [BIT_CNT_W-1:0] bit_cnt_r;
	logic [SAMPLE_W-1:0]  shift_r;

	assign fall          = lrck_r & ~i_AUD_DACLRCK;
	assign o_frame_start = fall;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_r    <= 1'b0;
			active_r  <= 1'b0;
			bit_cnt_r <= '0;
		end else begin
			lrck_r <= i_AUD_DACLRCK;
			if (fall) begin
				active_r  <= 1'b1;
				bit_cnt_r <= '0;
			end else if (active_r) begin
				bit_cnt_r <= bit_cnt_r + 1'b1;
				if (bit_cnt_r == BIT_CNT_W'(SAMPLE_W - 1)) begin
					active_r <= 1'b0;
				end
			end
		end
	end

	// silence when not playing, the SRAM word is ignored
	always_ff @(posedge i_AUD_BCLK) begin
		if (fall) begin
			shift_r <= i_en ? i_sram_rdata : '0;
		end else if (active_r) begin
			shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
		end
	end

	// MSB first, line held low outside the 16 data cycles
	assign o_AUD_DACDAT = active_r & shift_r[SAMPLE_W-1];

endmodule

// File: design/aud_core_top.sv
`timescale 1ns/1ps

module aud_core_top (
	input  logic                              i_AUD_BCLK,
	input  logic                              i_rst_n,
	input  aud_ctrl_pkg::key_s                i_keys,
	input  aud_ctrl_pkg::speed_s              i_speed,
	input  logic                              i_AUD_ADCLRCK,
	input  logic                              i_AUD_ADCDAT,
	input  logic                              i_AUD_DACLRCK,
	input  logic [aud_data_pkg::SAMPLE_W-1:0] i_sram_rdata,
	output aud_data_pkg::sram_req_s           o_sram,
	output logic                              o_AUD_DACDAT,
	output aud_ctrl_pkg::status_s             o_status
);

	import aud_ctrl_pkg::*;
	import aud_data_pkg::*;

	ctrl_cmd_s           cmd;
	logic                play_done;
	logic [SAMPLE_W-1:0] sample;
	logic                sample_valid;
	logic                frame_start;
	logic [ADDR_W-1:0]   rec_addr;
	logic [ADDR_W-1:0]   play_addr;

	aud_ctrl_fsm u_fsm (
		.i_AUD_BCLK  (i_AUD_BCLK),
		.i_rst_n     (i_rst_n),
		.i_keys      (i_keys),
		.i_play_done (play_done),
		.o_cmd       (cmd),
		.o_status    (o_status)
	);

	aud_addr_counter u_counter (
		.i_AUD_BCLK     (i_AUD_BCLK),
		.i_rst_n        (i_rst_n),
		.i_cmd          (cmd),
		.i_speed        (i_speed),
		.i_sample_valid (sample_valid),
		.i_frame_start  (frame_start),
		.o_rec_addr     (rec_addr),
		.o_play_addr    (play_addr),
		.o_play_done    (play_done)
	);

	i2s_recorder u_recorder (
		.i_AUD_BCLK     (i_AUD_BCLK),
		.i_rst_n        (i_rst_n),
		.i_AUD_ADCLRCK  (i_AUD_ADCLRCK),
		.i_AUD_ADCDAT   (i_AUD_ADCDAT),
		.o_sample       (sample),
		.o_sample_valid (sample_valid)
	);

	i2s_player u_player (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_AUD_DACLRCK (i_AUD_DACLRCK),
		.i_en          (cmd.play_en),
		.i_sram_rdata  (i_sram_rdata),
		.o_frame_start (frame_start),
		.o_AUD_DACDAT  (o_AUD_DACDAT)
	);

	// write strobe only on the valid cycle, the read address otherwise
	assign o_sram.we_n  = ~(cmd.rec_en & sample_valid);
	assign o_sram.addr  = cmd.rec_en ? rec_addr : play_addr;
	assign o_sram.wdata = sample;

endmodule

// File: dv/aud_chk.sv
`timescale 1ns/1ps

module aud_chk (
	input logic                      i_AUD_BCLK,
	input logic                      i_rst_n,
	input aud_ctrl_pkg::ctrl_state_e i_state,
	input logic                      i_play_en,
	input logic                      i_sample_valid,
	input logic                      i_frame_start,
	input logic                      i_we_n,
	input logic                      i_dacdat,
	input aud_ctrl_pkg::status_s     i_status
);

	import aud_ctrl_pkg::*;

	logic en_at_start;

	// player enable as loaded at the latest frame start
	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			en_at_start <= 1'b0;
		end else if (i_frame_start) begin
			en_at_start <= i_play_en;
		end
	end

	// one write per sample, only while the controller is recording
	a_write_window: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		!i_we_n |-> (i_state == S_RECD && i_sample_valid) ##1 i_we_n)
		else $error("SRAM write outside a single recording sample cycle");

	a_dac_silent: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		!en_at_start |-> !i_dacdat)
		else $error("DAC data driven while the player is disabled");

	// status is registered separately from the state, so both must agree
	a_status_state: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		(i_status.recording == (i_state == S_RECD)) &&
		(i_status.playing == (i_state == S_PLAY)))
		else $error("status does not match the controller state");

endmodule

bind aud_core_top aud_chk u_chk (
	.i_AUD_BCLK     (i_AUD_BCLK),
	.i_rst_n        (i_rst_n),
	.i_state        (u_fsm.state_r),
	.i_play_en      (cmd.play_en),
	.i_sample_valid (sample_valid),
	.i_frame_start  (frame_start),
	.i_we_n         (o_sram.we_n),
	.i_dacdat       (o_AUD_DACDAT),
	.i_status       (o_status)
);

// File: dv/aud_tb.sv
`timescale 1ns/1ps

module aud_tb;

	import aud_ctrl_pkg::*;
	import aud_data_pkg::*;

	localparam int FRAME_CYC = 40;
	localparam int TV_DEPTH  = 256;
	localparam int MEM_DEPTH = 1 << ADDR_W;

	localparam key_s KEY_NONE = 3'b000;
	localparam key_s KEY_REC  = 3'b100;
	localparam key_s KEY_PLAY = 3'b010;
	localparam key_s KEY_STOP = 3'b001;

	logic                clk;
	logic                rst_n;
	key_s                keys;
	speed_s              speed;
	logic                adc_lrck;
	logic                adc_dat;
	logic                dac_lrck;
	logic [SAMPLE_W-1:0] sram_rdata;
	sram_req_s           sram;
	logic                dac_dat;
	status_s             status;

	logic [SAMPLE_W-1:0] mem [0:MEM_DEPTH-1];
	logic [SAMPLE_W-1:0] tv [0:TV_DEPTH-1];
	logic [15:0]         lfsr;
	int                  wr_count = 0;
	int                  cycles = 0;
	int                  cycle_limit = 0;
	int                  errors;
	int                  checks;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	aud_core_top dut0 (
		.i_AUD_BCLK    (clk),
		.i_rst_n       (rst_n),
		.i_keys        (keys),
		.i_speed       (speed),
		.i_AUD_ADCLRCK (adc_lrck),
		.i_AUD_ADCDAT  (adc_dat),
		.i_AUD_DACLRCK (dac_lrck),
		.i_sram_rdata  (sram_rdata),
		.o_sram        (sram),
		.o_AUD_DACDAT  (dac_dat),
		.o_status      (status)
	);

	// external SRAM, combinational read
	always @(posedge clk) begin
		if (!sram.we_n) begin
			mem[sram.addr] <= sram.wdata;
			wr_count       <= wr_count + 1;
		end
	end
	assign sram_rdata = mem[sram.addr];

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the run went past %0d clock cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	// Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic flag_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		errors++;
	endtask

	// one I2S frame: left word on the ADC, noise on the right, DAC word captured
	task automatic run_frame(
		input  logic [SAMPLE_W-1:0] adc_word,
		input  key_s                key_act,
		output logic                was_playing,
		output logic [SAMPLE_W-1:0] dac_word
	);
		int                  c;
		logic [SAMPLE_W-1:0] adc_sh;
		adc_sh      = adc_word;
		dac_word    = '0;
		was_playing = 1'b0;
		for (c = 0; c < FRAME_CYC; c++) begin
			@(posedge clk);
			adc_lrck <= (c >= 20);
			dac_lrck <= (c >= 20);
			if (c >= 1 && c <= SAMPLE_W) begin
				adc_dat <= adc_sh[SAMPLE_W-1];
				adc_sh = adc_sh << 1;
			end else if (c >= 21 && c <= 20 + SAMPLE_W) begin
				adc_dat <= lfsr[0];
				lfsr = lfsr_next(lfsr);
			end else begin
				adc_dat <= 1'b0;
			end
			// press early in the right half, release a few cycles later
			if (c == 26) begin
				keys <= key_act;
			end else if (c == 30) begin
				keys <= KEY_NONE;
			end
			@(negedge clk);
			if (c == 0) begin
				was_playing = status.playing;
			end else if (c <= SAMPLE_W) begin
				dac_word = {dac_word[SAMPLE_W-2:0], dac_dat};
			end
		end
	endtask

	initial begin
		int                  ptr;
		int                  t;
		int                  n;
		int                  p;
		int                  e;
		int                  j;
		int                  k;
		int                  got;
		int                  frames;
		int                  wr_base;
		logic                playing;
		logic [SAMPLE_W-1:0] word;
		key_s                key;

		// LRCK starts high so the first frame opens with a falling edge
		rst_n    = 1'b1;
		keys     = KEY_NONE;
		speed    = '0;
		adc_lrck = 1'b1;
		adc_dat  = 1'b0;
		dac_lrck = 1'b1;
		lfsr     = 16'd85;
		errors   = 0;
		checks   = 0;

		$readmemh("dv/aud_tests.txt", tv);
		frames = 2;
		ptr    = 0;
		while (tv[ptr] != 16'h0 && ptr < TV_DEPTH - 8) begin
			n      = int'(tv[ptr]);
			p      = int'(tv[ptr + 2]);
			e      = int'(tv[ptr + 3 + n]);
			frames = frames + n + e + 3 + ((p != 0) ? 6 : 0);
			ptr    = ptr + 4 + n + e;
		end
		cycle_limit = frames * FRAME_CYC * 2;

		repeat (8) @(posedge clk);
		rst_n <= 1'b0;

		run_frame(16'hFFFF, KEY_NONE, playing, word);
		checks++;
		if (status != '0 || playing || word != '0 || wr_count != 0 || !sram.we_n) begin
			flag_error("outputs not idle after reset");
		end

		ptr = 0;
		t   = 0;
		while (tv[ptr] != 16'h0) begin
			n = int'(tv[ptr]);
			p = int'(tv[ptr + 2]);
			e = int'(tv[ptr + 3 + n]);

			// record, the marker word must never reach memory
			wr_base = wr_count;
			run_frame(16'hDEAD, KEY_REC, playing, word);
			for (j = 0; j < n; j++) begin
				if (j == n - 1) begin
					key = KEY_STOP;
				end else if (p != 0 && j == p - 1) begin
					key = KEY_REC;
				end else begin
					key = KEY_NONE;
				end
				run_frame(tv[ptr + 3 + j], key, playing, word);
				if (key == KEY_REC) begin
					for (k = 0; k < 3; k++) begin
						run_frame(16'hDEAD, (k == 2) ? KEY_REC : KEY_NONE, playing, word);
					end
				end
			end
			checks++;
			if (wr_count - wr_base != n || status != '0) begin
				flag_error($sformatf("test %0d wrote %0d words, expected %0d",
					t, wr_count - wr_base, n));
			end

			@(posedge clk);
			speed <= speed_s'(tv[ptr + 1][3:0]);
			run_frame(16'h0, KEY_PLAY, playing, word);
			got     = 0;
			j       = 0;
			playing = 1'b1;
			while (playing) begin
				key = (p != 0 && j == p - 1) ? KEY_PLAY : KEY_NONE;
				run_frame(16'h0, key, playing, word);
				checks++;
				if (playing) begin
					if (got >= e) begin
						flag_error($sformatf("test %0d played more than %0d words", t, e));
					end else if (word != tv[ptr + 4 + n + got]) begin
						flag_error($sformatf("test %0d word %0d is %h, expected %h",
							t, got, word, tv[ptr + 4 + n + got]));
					end
					got++;
				end else if (word != '0) begin
					flag_error($sformatf("test %0d DAC not silent after play, %h", t, word));
				end
				// paused frames must stay silent
				if (key == KEY_PLAY) begin
					for (k = 0; k < 3; k++) begin
						run_frame(16'h0, (k == 2) ? KEY_PLAY : KEY_NONE, playing, word);
						checks++;
						if (playing || word != '0) begin
							flag_error($sformatf("test %0d output during play pause", t));
						end
					end
					playing = 1'b1;
				end
				j++;
			end
			checks++;
			if (got != e || status != '0) begin
				flag_error($sformatf("test %0d played %0d words, expected %0d", t, got, e));
			end
			ptr = ptr + 4 + n + e;
			t++;
		end

		$display("tests: %0d, checks: %0d, errors: %0d", t, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: dv/aud_tests.txt
// per test: sample count, speed {slow, factor[2:0]}, pause index (0 for none),
// then the recorded samples, the expected word count and the expected playback
// normal speed
0006 0000 0000
1234 a5a5 0f0f 8001 7ffe c3c3
0006
1234 a5a5 0f0f 8001 7ffe c3c3
// fast, factor 2
0007 0002 0000
1111 2222 3333 4444 5555 6666 7777
0003
1111 4444 7777
// slow, factor 1
0003 0009 0000
abcd 0001 fedc
0006
abcd abcd 0001 0001 fedc fedc
// pause after two samples and after two played words
0005 0000 0002
9a9a 0bb0 c00c 5dd5 e1e1
0005
9a9a 0bb0 c00c 5dd5 e1e1
// slow, factor 2, pause in the middle of a repeat
0003 000a 0002
0a0a 0b0b 0c0c
0009
0a0a 0a0a 0a0a 0b0b 0b0b 0b0b 0c0c 0c0c 0c0c
// end of list
0000

// File: build.f
design/aud_ctrl_pkg.sv
design/aud_data_pkg.sv
design/aud_ctrl_fsm.sv
design/aud_addr_counter.sv
design/i2s_recorder.sv
design/i2s_player.sv
design/aud_core_top.sv
dv/aud_chk.sv
dv/aud_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the audio core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module aud_tb -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vaud_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Test failures found" "$log"; then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation passed"
exit 0
